//--- rtl/uart_rx_pkg.sv
`default_nettype none

package uart_rx_pkg;

    // Receiver ticks per bit period.
    localparam int OVERSAMPLE = 16;

    // Width of a received character. Shorter frames are right-aligned.
    localparam int DATA_W = 8;

    typedef enum logic [1:0] {
        data_bits_5,
        data_bits_6,
        data_bits_7,
        data_bits_8
    } data_bits_e;

    typedef enum logic {
        parity_even,
        parity_odd
    } parity_e;

    typedef enum logic {
        stop_bits_1,
        stop_bits_2
    } stop_bits_e;

    // Entry count at which the FIFO raises its trigger flag.
    typedef enum logic [1:0] {
        trig_1,
        trig_quarter,
        trig_half,
        trig_near_full
    } trig_level_e;

    typedef enum logic [2:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_parity,
        rx_stop
    } rx_state_e;

endpackage

`default_nettype wire

//--- rtl/rx_char_if.sv
`default_nettype none

interface rx_char_if;

    import uart_rx_pkg::*;

    logic [DATA_W-1:0] data;
    logic              parity_err;
    logic              stop_err;

    // One-cycle strobe; the other fields are only meaningful while it is high.
    logic              valid;

    modport source (
        output data,
        output parity_err,
        output stop_err,
        output valid
    );

    modport sink (
        input data,
        input parity_err,
        input stop_err,
        input valid
    );

endinterface

`default_nettype wire

//--- rtl/uart_baud_gen.sv
`default_nettype none

module uart_baud_gen #(
    parameter int CLK_DIV = 27
) (
    input  wire logic clk,
    input  wire logic rst_i,
    input  wire logic rx_en_i,
    output logic      tick_o
);

    localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [CNT_W-1:0] div_cnt;
    logic             wrap;

    assign wrap = (div_cnt == CNT_W'(CLK_DIV - 1));

    // The divider holds at zero while reception is disabled, so the first
    // tick after enabling comes a full CLK_DIV clocks later.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            div_cnt <= '0;
            tick_o  <= 1'b0;
        end else if (!rx_en_i) begin
            div_cnt <= '0;
            tick_o  <= 1'b0;
        end else if (wrap) begin
            div_cnt <= '0;
            tick_o  <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick_o  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_receiver.sv
`default_nettype none

module uart_receiver (
    input  wire logic                   clk,
    input  wire logic                   rst_i,
    input  wire logic                   tick_i,
    input  wire logic                   rx_i,
    input  wire logic                   parity_en_i,
    input  wire uart_rx_pkg::parity_e    parity_type_i,
    input  wire uart_rx_pkg::stop_bits_e stop_bit_num_i,
    input  wire uart_rx_pkg::data_bits_e data_bit_num_i,
    rx_char_if.source                   char_o
);

    import uart_rx_pkg::*;

    localparam int TICK_W   = $clog2(OVERSAMPLE);
    localparam int BIT_W    = $clog2(DATA_W);
    localparam int HALF_BIT = OVERSAMPLE / 2;
    localparam int MIN_BITS = 5;

    logic              rx_meta;
    logic              rx_sync;
    rx_state_e         state_q;
    logic [TICK_W-1:0] tick_cnt;
    logic [BIT_W-1:0]  bit_cnt;
    logic [BIT_W-1:0]  last_bit;
    logic [DATA_W-1:0] shift_q;
    logic              parity_err_q;
    logic              stop_err_q;
    logic              valid_q;
    logic              bit_done;
    logic              start_ok;
    logic              sample_data;

    // Two-flop synchronizer. The line idles high.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
        end
    end

    // Index of the last data bit, 4 to 7.
    assign last_bit = BIT_W'(MIN_BITS - 1) + BIT_W'(data_bit_num_i);

    // A bit midpoint is reached on the 16th tick after the previous sample.
    assign bit_done = tick_i && (tick_cnt == TICK_W'(OVERSAMPLE - 1));

    assign start_ok = (state_q == rx_start) && tick_i &&
                      (tick_cnt == TICK_W'(HALF_BIT - 1)) && !rx_sync;

    assign sample_data = (state_q == rx_data) && bit_done;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q      <= rx_idle;
            tick_cnt     <= '0;
            bit_cnt      <= '0;
            parity_err_q <= 1'b0;
            stop_err_q   <= 1'b0;
            valid_q      <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (tick_i) begin
                tick_cnt <= bit_done ? '0 : tick_cnt + 1'b1;
            end

            case (state_q)
                rx_idle: begin
                    tick_cnt <= '0;
                    if (tick_i && !rx_sync) begin
                        state_q <= rx_start;
                    end
                end

                rx_start: begin
                    // Check the start bit again half a bit after the edge.
                    // A glitch sends the receiver back to idle.
                    if (tick_i && tick_cnt == TICK_W'(HALF_BIT - 1)) begin
                        tick_cnt <= '0;
                        if (start_ok) begin
                            state_q      <= rx_data;
                            bit_cnt      <= '0;
                            parity_err_q <= 1'b0;
                            stop_err_q   <= 1'b0;
                        end else begin
                            state_q <= rx_idle;
                        end
                    end
                end

                rx_data: begin
                    if (bit_done) begin
                        if (bit_cnt == last_bit) begin
                            bit_cnt <= '0;
                            state_q <= parity_en_i ? rx_parity : rx_stop;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end

                rx_parity: begin
                    if (bit_done) begin
                        // Unused upper data bits are zero and add nothing.
                        parity_err_q <= (^{shift_q, rx_sync}) ^ (parity_type_i == parity_odd);
                        state_q      <= rx_stop;
                    end
                end

                rx_stop: begin
                    if (bit_done) begin
                        if (!rx_sync) begin
                            stop_err_q <= 1'b1;
                        end
                        if (stop_bit_num_i == stop_bits_2 && bit_cnt == '0) begin
                            bit_cnt <= BIT_W'(1);
                        end else begin
                            state_q <= rx_idle;
                            valid_q <= 1'b1;
                        end
                    end
                end

                default: begin
                    state_q <= rx_idle;
                end
            endcase
        end
    end

    // Data bits arrive LSB first and land at their final position.
    always_ff @(posedge clk) begin
        if (start_ok) begin
            shift_q <= '0;
        end else if (sample_data) begin
            shift_q[bit_cnt] <= rx_sync;
        end
    end

    assign char_o.data       = shift_q;
    assign char_o.parity_err = parity_err_q;
    assign char_o.stop_err   = stop_err_q;
    assign char_o.valid      = valid_q;

    valid_is_pulse: assert property (
        @(posedge clk) disable iff (rst_i)
        valid_q |=> !valid_q
    ) else $error("receiver valid high in two adjacent cycles");

    tick_cnt_range: assert property (
        @(posedge clk) disable iff (rst_i)
        tick_cnt <= TICK_W'(OVERSAMPLE - 1)
    ) else $error("receiver tick counter out of range");

endmodule

`default_nettype wire

//--- rtl/rx_char_buffer.sv
`default_nettype none

module rx_char_buffer #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic                      clk,
    input  wire logic                      rst_i,
    rx_char_if.sink                        char_i,
    input  wire logic                      fifo_en_i,
    input  wire uart_rx_pkg::trig_level_e   fifo_rx_trig_level_i,
    input  wire logic                      fifo_rx_pop_i,
    output logic [uart_rx_pkg::DATA_W-1:0] data_o,
    output logic                           data_valid_o,
    output logic                           parity_err_o,
    output logic                           stop_bit_err_o,
    output logic                           fifo_rx_triggered_o,
    output logic                           fifo_rx_empty_o,
    output logic                           fifo_rx_full_o
);

    import uart_rx_pkg::*;

    localparam int PTR_W   = $clog2(FIFO_DEPTH);
    localparam int CNT_W   = PTR_W + 1;
    localparam int ENTRY_W = DATA_W + 2;
    localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(FIFO_DEPTH);

    // Entry layout is {parity_err, stop_err, data}.
    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
    logic [ENTRY_W-1:0] head;
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic [CNT_W-1:0]   trig_count;
    logic               push;
    logic               pop;

    assign fifo_rx_empty_o = (count == '0);
    assign fifo_rx_full_o  = (count == DEPTH_CNT);

    // A character that meets a full buffer is lost.
    assign push = fifo_en_i && char_i.valid && !fifo_rx_full_o;
    assign pop  = fifo_rx_pop_i && !fifo_rx_empty_o;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {char_i.parity_err, char_i.stop_err, char_i.data};
        end
    end

    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_comb begin
        case (fifo_rx_trig_level_i)
            trig_1:       trig_count = CNT_W'(1);
            trig_quarter: trig_count = CNT_W'(FIFO_DEPTH / 4);
            trig_half:    trig_count = CNT_W'(FIFO_DEPTH / 2);
            default:      trig_count = CNT_W'(FIFO_DEPTH - 2);
        endcase
    end

    assign fifo_rx_triggered_o = (count >= trig_count);

    // In bypass mode the receiver strobe passes straight to the output.
    always_comb begin
        if (fifo_en_i) begin
            data_o         = head[DATA_W-1:0];
            stop_bit_err_o = head[DATA_W];
            parity_err_o   = head[DATA_W+1];
            data_valid_o   = !fifo_rx_empty_o;
        end else begin
            data_o         = char_i.data;
            stop_bit_err_o = char_i.stop_err;
            parity_err_o   = char_i.parity_err;
            data_valid_o   = char_i.valid;
        end
    end

    count_bound: assert property (
        @(posedge clk) disable iff (rst_i)
        count <= DEPTH_CNT
    ) else $error("FIFO count exceeds depth");

    push_pop_balance: assert property (
        @(posedge clk) disable iff (rst_i)
        push && pop |=> $stable(count)
    ) else $error("FIFO count changed on simultaneous push and pop");

endmodule

`default_nettype wire

//--- rtl/uart_rx_top.sv
`default_nettype none

module uart_rx_top #(
    parameter int CLK_DIV    = 27,
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic                      clk,
    input  wire logic                      rst_i,
    input  wire logic                      rx_en_i,
    input  wire logic                      rx_i,
    input  wire logic                      parity_en_i,
    input  wire logic                      parity_type_i,
    input  wire logic                      stop_bit_num_i,
    input  wire logic [1:0]                data_bit_num_i,
    input  wire logic                      fifo_en_i,
    input  wire logic [1:0]                fifo_rx_trig_level_i,
    input  wire logic                      fifo_rx_pop_i,
    output logic [uart_rx_pkg::DATA_W-1:0] data_o,
    output logic                           data_valid_o,
    output logic                           parity_err_o,
    output logic                           stop_bit_err_o,
    output logic                           fifo_rx_triggered_o,
    output logic                           fifo_rx_empty_o,
    output logic                           fifo_rx_full_o
);

    import uart_rx_pkg::*;

    logic tick;

    rx_char_if rx_char ();

    uart_baud_gen #(
        .CLK_DIV (CLK_DIV)
    ) i_baud_gen (
        .clk     (clk),
        .rst_i   (rst_i),
        .rx_en_i (rx_en_i),
        .tick_o  (tick)
    );

    uart_receiver i_receiver (
        .clk            (clk),
        .rst_i          (rst_i),
        .tick_i         (tick),
        .rx_i           (rx_i),
        .parity_en_i    (parity_en_i),
        .parity_type_i  (parity_e'(parity_type_i)),
        .stop_bit_num_i (stop_bits_e'(stop_bit_num_i)),
        .data_bit_num_i (data_bits_e'(data_bit_num_i)),
        .char_o         (rx_char.source)
    );

    rx_char_buffer #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_char_buffer (
        .clk                  (clk),
        .rst_i                (rst_i),
        .char_i               (rx_char.sink),
        .fifo_en_i            (fifo_en_i),
        .fifo_rx_trig_level_i (trig_level_e'(fifo_rx_trig_level_i)),
        .fifo_rx_pop_i        (fifo_rx_pop_i),
        .data_o               (data_o),
        .data_valid_o         (data_valid_o),
        .parity_err_o         (parity_err_o),
        .stop_bit_err_o       (stop_bit_err_o),
        .fifo_rx_triggered_o  (fifo_rx_triggered_o),
        .fifo_rx_empty_o      (fifo_rx_empty_o),
        .fifo_rx_full_o       (fifo_rx_full_o)
    );

endmodule

`default_nettype wire

//--- test/tb_uart_rx_top.sv
`default_nettype none

module tb_uart_rx_top;

    import uart_rx_pkg::*;

    localparam int CLK_DIV     = 4;
    localparam int FIFO_DEPTH  = 16;
    localparam int BIT_CLKS    = CLK_DIV * OVERSAMPLE;
    localparam int NUM_FRAMES  = 20 + 12 + 16 + 2 + 17 + 3;
    localparam int CYCLE_LIMIT = NUM_FRAMES * 12 * BIT_CLKS + 2000;

    typedef struct packed {
        logic [7:0] data;
        logic       parity_err;
        logic       stop_err;
    } char_t;

    logic       clk = 1'b0;
    logic       rst_i;
    logic       rx_en_i;
    logic       rx_i;
    logic       parity_en_i;
    logic       parity_type_i;
    logic       stop_bit_num_i;
    logic [1:0] data_bit_num_i;
    logic       fifo_en_i;
    logic [1:0] fifo_rx_trig_level_i;
    logic       fifo_rx_pop_i;
    logic [7:0] data_o;
    logic       data_valid_o;
    logic       parity_err_o;
    logic       stop_bit_err_o;
    logic       fifo_rx_triggered_o;
    logic       fifo_rx_empty_o;
    logic       fifo_rx_full_o;

    char_t expect_q[$];
    int    errors = 0;
    int    checks = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    test_errors = 0;
    int    cycles = 0;

    uart_rx_top #(
        .CLK_DIV    (CLK_DIV),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_dut (
        .clk                  (clk),
        .rst_i                (rst_i),
        .rx_en_i              (rx_en_i),
        .rx_i                 (rx_i),
        .parity_en_i          (parity_en_i),
        .parity_type_i        (parity_type_i),
        .stop_bit_num_i       (stop_bit_num_i),
        .data_bit_num_i       (data_bit_num_i),
        .fifo_en_i            (fifo_en_i),
        .fifo_rx_trig_level_i (fifo_rx_trig_level_i),
        .fifo_rx_pop_i        (fifo_rx_pop_i),
        .data_o               (data_o),
        .data_valid_o         (data_valid_o),
        .parity_err_o         (parity_err_o),
        .stop_bit_err_o       (stop_bit_err_o),
        .fifo_rx_triggered_o  (fifo_rx_triggered_o),
        .fifo_rx_empty_o      (fifo_rx_empty_o),
        .fifo_rx_full_o       (fifo_rx_full_o)
    );

    always #10 clk = ~clk;

    // Expected character for a frame, derived from the frame format rules.
    function automatic char_t expect_char(input logic [7:0] value, input int nbits,
                                          input logic par_en, input logic bad_par,
                                          input logic bad_stop);
        char_t c;
        c.data       = value & (8'hff >> (8 - nbits));
        c.parity_err = par_en && bad_par;
        c.stop_err   = bad_stop;
        return c;
    endfunction

    task automatic drive_bit(input logic level);
        rx_i = level;
        repeat (BIT_CLKS) @(posedge clk);
        #2;
    endtask

    // Start bit, data LSB first, optional parity, stop bits, then one idle bit.
    task automatic send_frame(input logic [7:0] value, input logic bad_par,
                              input logic bad_stop);
        int         nbits;
        logic [7:0] masked;
        logic       pbit;
        nbits  = data_bit_num_i + 5;
        masked = value & (8'hff >> (8 - nbits));
        pbit   = (^masked) ^ parity_type_i ^ bad_par;
        drive_bit(1'b0);
        for (int i = 0; i < nbits; i++) begin
            drive_bit(value[i]);
        end
        if (parity_en_i) begin
            drive_bit(pbit);
        end
        drive_bit(!bad_stop);
        if (stop_bit_num_i) begin
            drive_bit(!bad_stop);
        end
        drive_bit(1'b1);
    endtask

    task automatic send_char(input logic [7:0] value, input logic bad_par,
                             input logic bad_stop, input logic expected);
        if (expected) begin
            expect_q.push_back(expect_char(value, data_bit_num_i + 5, parity_en_i,
                                           bad_par, bad_stop));
        end
        send_frame(value, bad_par, bad_stop);
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s expected %b actual %b", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_char();
        char_t exp;
        if (expect_q.size() == 0) begin
            $display("%0t: character 0x%h arrived while none was expected", $time, data_o);
            errors++;
        end else begin
            exp = expect_q.pop_front();
            checks++;
            if (data_o !== exp.data) begin
                $display("[ERROR] %0t data_o expected 0x%h actual 0x%h",
                         $time, exp.data, data_o);
                errors++;
            end
            check_flag("parity_err_o", parity_err_o, exp.parity_err);
            check_flag("stop_bit_err_o", stop_bit_err_o, exp.stop_err);
        end
    endtask

    task automatic end_test(input string name);
        if (expect_q.size() != 0) begin
            $display("%0t: %0d expected characters never arrived in %s",
                     $time, expect_q.size(), name);
            errors += expect_q.size();
            expect_q.delete();
        end
        tests_run++;
        if (errors != test_errors) begin
            tests_failed++;
        end
        $display("%s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    // Bypass characters are checked on the strobe, buffered ones on each pop.
    always @(negedge clk) begin
        if (!rst_i && data_valid_o && (!fifo_en_i || fifo_rx_pop_i)) begin
            check_char();
        end
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run timed out after %0d cycles", cycles);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic bad;
        void'($urandom(32'hdea4_9985));
        rst_i                = 1'b1;
        rx_en_i              = 1'b0;
        rx_i                 = 1'b1;
        parity_en_i          = 1'b0;
        parity_type_i        = parity_even;
        stop_bit_num_i       = stop_bits_1;
        data_bit_num_i       = data_bits_8;
        fifo_en_i            = 1'b0;
        fifo_rx_trig_level_i = trig_1;
        fifo_rx_pop_i        = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst_i = 1'b0;
        check_flag("fifo_rx_empty_o", fifo_rx_empty_o, 1'b1);
        check_flag("fifo_rx_full_o", fifo_rx_full_o, 1'b0);
        check_flag("fifo_rx_triggered_o", fifo_rx_triggered_o, 1'b0);
        check_flag("data_valid_o", data_valid_o, 1'b0);
        rx_en_i = 1'b1;
        drive_bit(1'b1);

        for (int i = 0; i < 20; i++) begin
            send_char(8'($urandom), 1'b0, 1'b0, 1'b1);
        end
        end_test("bypass 8N1");

        stop_bit_num_i = stop_bits_2;
        for (int w = 0; w < 3; w++) begin
            data_bit_num_i = 2'(w);
            for (int i = 0; i < 4; i++) begin
                send_char(8'($urandom), 1'b0, 1'b0, 1'b1);
            end
        end
        end_test("short data widths");

        stop_bit_num_i = stop_bits_1;
        data_bit_num_i = data_bits_8;
        parity_en_i    = 1'b1;
        for (int p = 0; p < 2; p++) begin
            parity_type_i = p[0];
            for (int i = 0; i < 8; i++) begin
                bad = (i < 2) ? (i == 0) : 1'($urandom);
                send_char(8'($urandom), bad, 1'b0, 1'b1);
            end
        end
        end_test("parity");

        parity_en_i = 1'b0;
        send_char(8'h5a, 1'b0, 1'b1, 1'b1);
        send_char(8'ha5, 1'b0, 1'b0, 1'b1);
        end_test("stop bit error");

        fifo_en_i            = 1'b1;
        fifo_rx_trig_level_i = trig_quarter;
        check_flag("fifo_rx_empty_o", fifo_rx_empty_o, 1'b1);
        for (int k = 1; k <= 17; k++) begin
            send_char(8'($urandom), 1'b0, 1'b0, k <= 16);
            check_flag("fifo_rx_empty_o", fifo_rx_empty_o, 1'b0);
            check_flag("fifo_rx_triggered_o", fifo_rx_triggered_o, k >= 4);
            check_flag("fifo_rx_full_o", fifo_rx_full_o, k >= 16);
        end
        for (int i = 0; i < 16; i++) begin
            if (!data_valid_o) begin
                $display("%0t: FIFO ran empty after %0d pops", $time, i);
                errors++;
            end
            fifo_rx_pop_i = 1'b1;
            @(posedge clk);
            #2;
            fifo_rx_pop_i = 1'b0;
        end
        check_flag("fifo_rx_empty_o", fifo_rx_empty_o, 1'b1);
        check_flag("fifo_rx_full_o", fifo_rx_full_o, 1'b0);
        check_flag("fifo_rx_triggered_o", fifo_rx_triggered_o, 1'b0);
        end_test("FIFO fill and drain");

        rx_en_i = 1'b0;
        for (int i = 0; i < 3; i++) begin
            send_char(8'($urandom), 1'b0, 1'b0, 1'b0);
            check_flag("fifo_rx_empty_o", fifo_rx_empty_o, 1'b1);
            check_flag("data_valid_o", data_valid_o, 1'b0);
        end
        end_test("receiver disabled");

        $display("%0d tests run, %0d failed, %0d characters checked, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
rtl/uart_rx_pkg.sv
rtl/rx_char_if.sv
rtl/uart_baud_gen.sv
rtl/uart_receiver.sv
rtl/rx_char_buffer.sv
rtl/uart_rx_top.sv
test/tb_uart_rx_top.sv

//--- Bender.yml
package:
  name: uart_rx

sources:
  - rtl/uart_rx_pkg.sv
  - rtl/rx_char_if.sv
  - rtl/uart_baud_gen.sv
  - rtl/uart_receiver.sv
  - rtl/rx_char_buffer.sv
  - rtl/uart_rx_top.sv
  - target: test
    files:
      - test/tb_uart_rx_top.sv
